// ==== muldiv_cases.txt ====
# op (funct3, hex)  a (hex)  b (hex)  expected result (hex)
# ops 0 MUL, 1 MULH, 2 MULHSU, 3 MULHU, 4 DIV, 5 DIVU, 6 REM, 7 REMU
0 00000007 00000006 0000002a
0 fffffffd 00000005 fffffff1
0 ffffffff ffffffff 00000001
0 12345678 00000000 00000000
1 fffffffd 00000005 ffffffff
1 80000000 80000000 40000000
1 7fffffff 7fffffff 3fffffff
1 80000000 7fffffff c0000000
2 ffffffff ffffffff ffffffff
2 00000002 ffffffff 00000001
2 80000000 00000002 ffffffff
3 ffffffff ffffffff fffffffe
3 fffffffd 00000005 00000004
4 ffffffec 00000006 fffffffd
4 00000014 fffffffa fffffffd
4 ffffffec fffffffa 00000003
4 00000007 00000000 ffffffff
4 80000000 ffffffff 80000000
4 00000000 00000005 00000000
5 ffffffff 00000002 7fffffff
5 ffffffec 00000006 2aaaaaa7
5 12345678 00000000 ffffffff
6 ffffffec 00000006 fffffffe
6 00000014 fffffffa 00000002
6 ffffffec fffffffa fffffffe
6 fffffff9 00000000 fffffff9
6 80000000 ffffffff 00000000
7 ffffffec 00000006 00000002
7 00000005 00000000 00000005
7 ffffffff 00000010 0000000f
7 00000000 00000003 00000000

// ==== muldiv.f ====
muldiv_pkg.sv
muldiv_ctrl.sv
muldiv_counter.sv
mul_unit.sv
div_unit.sv
muldiv_top.sv
muldiv_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the muldiv testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module muldiv_tb \
  -f muldiv.f \
  --Mdir obj_dir -o muldiv_sim

./obj_dir/muldiv_sim 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "Simulation passed"
  exit 0
else
  echo "Simulation failed, see sim.log"
  exit 1
fi

// ==== muldiv_tb.sv ====
`timescale 1ns/1ps

module muldiv_tb;

  localparam int XLEN = 32;
  localparam int DRIVE_DELAY = 5;  // ns after the rising edge

  logic                     clk;
  logic                     rst;
  muldiv_pkg::muldiv_req_t  req;
  muldiv_pkg::muldiv_resp_t resp;

  logic [2:0]  case_op[$];
  logic [31:0] case_a[$];
  logic [31:0] case_b[$];
  logic [31:0] case_exp[$];

  integer seed = 32'h7333_d74b;
  int     cycles = 0;
  int     limit = 0;         // Zero until the cases are loaded
  int     ready_pulses = 0;  // Cycles seen with ready high
  int     requests = 0;      // Requests expected to complete

  muldiv_top #(
    .XLEN (XLEN)
  ) i_dut (
    .clk  (clk),
    .rst  (rst),
    .req  (req),
    .resp (resp)
  );

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #50 clk = ~clk;
    end
  end

  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (limit > 0 && cycles >= limit)
    begin
      $display("Timeout: the run went past %0d clock cycles without finishing", limit);
      $display("*** FAILED ***");
      $fatal(1, "simulation timed out");
    end
  end

  always @(negedge clk)
  begin
    if (!rst && resp.ready)
    begin
      ready_pulses = ready_pulses + 1;
    end
  end

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected)
    begin
      $display("Error at %0t: %s, got %h, expected %h", $time, what, actual, expected);
      $display("*** FAILED ***");
      $fatal(1, "check failed");
    end
  endtask

  // Lines that do not scan as four hex words are comments
  task automatic load_cases();
    int          fd;
    string       line;
    logic [31:0] f_op;
    logic [31:0] f_a;
    logic [31:0] f_b;
    logic [31:0] f_exp;
    fd = $fopen("muldiv_cases.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the case file muldiv_cases.txt");
      $display("*** FAILED ***");
      $fatal(1, "missing case file");
    end
    while (!$feof(fd))
    begin
      if ($fgets(line, fd) > 0)
      begin
        if ($sscanf(line, "%h %h %h %h", f_op, f_a, f_b, f_exp) == 4)
        begin
          case_op.push_back(f_op[2:0]);
          case_a.push_back(f_a);
          case_b.push_back(f_b);
          case_exp.push_back(f_exp);
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic run_case(input logic [2:0] op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] expected);
    int latency;
    int expect_lat;
    expect_lat = op[2] ? XLEN + 2 : 2;  // Divide group: load, XLEN steps, done
    @(posedge clk);
    #DRIVE_DELAY;
    req.valid = 1'b1;
    req.op    = muldiv_pkg::muldiv_op_e'(op);
    req.a     = a;
    req.b     = b;
    requests++;
    @(posedge clk);  // Capture edge
    latency = 0;
    @(negedge clk);
    while (!resp.ready)
    begin
      @(posedge clk);
      latency++;
      @(negedge clk);
    end
    check_value(latency, expect_lat, $sformatf("latency of op %0d on %h, %h", op, a, b));
    check_value(resp.res, expected, $sformatf("result of op %0d on %h, %h", op, a, b));
    @(posedge clk);
    #DRIVE_DELAY;
    req.valid = 1'b0;
    @(negedge clk);
    check_value(resp.ready, 1'b0, "ready still high one cycle later");
  endtask

  // Divide dropped part way, no ready may follow
  task automatic abort_check();
    int pulses_before;
    pulses_before = ready_pulses;
    @(posedge clk);
    #DRIVE_DELAY;
    req.valid = 1'b1;
    req.op    = muldiv_pkg::DIV;
    req.a     = 32'd1000;
    req.b     = 32'd7;
    repeat (10) @(posedge clk);
    #DRIVE_DELAY;
    req.valid = 1'b0;
    repeat (2 * XLEN) @(posedge clk);  // Well past a full divide
    check_value(ready_pulses, pulses_before, "ready pulse after an abandoned divide");
  endtask

  initial
  begin
    int gap;
    rst = 1'b1;
    req = '0;
    load_cases();
    if (case_op.size() == 0)
    begin
      $display("The case file muldiv_cases.txt holds no cases");
      $display("*** FAILED ***");
      $fatal(1, "empty case file");
    end
    limit = 40 * case_op.size() + 16 + 200;
    repeat (16) @(posedge clk);
    #DRIVE_DELAY;
    rst = 1'b0;
    @(negedge clk);
    check_value(resp.ready, 1'b0, "ready high after reset");
    check_value(resp.res, 32'h0, "result not cleared by reset");
    foreach (case_op[i])
    begin
      run_case(case_op[i], case_a[i], case_b[i], case_exp[i]);
      gap = {$random(seed)} % 4;  // Idle cycles between requests
      repeat (gap) @(posedge clk);
    end
    abort_check();
    run_case(3'b000, 32'h0000_1234, 32'h0000_0010, 32'h0001_2340);
    @(posedge clk);
    check_value(ready_pulses, requests, "count of ready pulses");
    $display("*** PASSED ***");
    $finish;
  end

endmodule

// ==== muldiv_top.sv ====
`timescale 1ns/1ps

module muldiv_top #(
  parameter int XLEN = 32
) (
  input  logic                     clk,
  input  logic                     rst,
  input  muldiv_pkg::muldiv_req_t  req,
  output muldiv_pkg::muldiv_resp_t resp
);

  logic            mul_start;
  logic            div_start;
  logic            step;
  logic            is_div;
  logic            ready;
  logic            last;
  logic            mul_done;
  logic [XLEN-1:0] mul_res;
  logic [XLEN-1:0] div_res;

  muldiv_ctrl i_ctrl (
    .clk       (clk),
    .rst       (rst),
    .req       (req),
    .last      (last),
    .mul_done  (mul_done),
    .mul_start (mul_start),
    .div_start (div_start),
    .step      (step),
    .is_div    (is_div),
    .ready     (ready)
  );

  muldiv_counter #(
    .COUNT (XLEN)  // One iteration per quotient bit
  ) i_counter (
    .clk  (clk),
    .rst  (rst),
    .load (div_start),
    .en   (step),
    .last (last)
  );

  mul_unit #(
    .XLEN (XLEN)
  ) i_mul (
    .clk   (clk),
    .rst   (rst),
    .start (mul_start),
    .op    (req.op),
    .a     (req.a),
    .b     (req.b),
    .done  (mul_done),
    .res   (mul_res)
  );

  div_unit #(
    .XLEN (XLEN)
  ) i_div (
    .clk   (clk),
    .rst   (rst),
    .start (div_start),
    .step  (step),
    .op    (req.op),
    .a     (req.a),
    .b     (req.b),
    .res   (div_res)
  );

  // Both sources are registered and stable while the controller is in DONE
  always_comb
  begin
    resp.ready = ready;
    resp.res   = is_div ? div_res : mul_res;
  end

endmodule

// ==== div_unit.sv ====
`timescale 1ns/1ps

module div_unit #(
  parameter int XLEN = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  logic                   step,
  input  muldiv_pkg::muldiv_op_e op,
  input  logic [XLEN-1:0]        a,
  input  logic [XLEN-1:0]        b,
  output logic [XLEN-1:0]        res
);

  localparam logic [XLEN-1:0] MOST_NEG = {1'b1, {(XLEN-1){1'b0}}};

  logic            op_signed;
  logic            op_rem;
  logic            a_neg;
  logic            b_neg;
  logic [XLEN-1:0] mag_a;
  logic [XLEN-1:0] mag_b;
  logic [XLEN-1:0] quo;      // Dividend shifting out, quotient shifting in
  logic [XLEN-1:0] rem;      // Partial remainder
  logic [XLEN-1:0] dvs;      // Divisor magnitude
  logic [XLEN:0]   rem_sh;
  logic [XLEN:0]   rem_sub;
  logic            fits;     // Divisor goes into the shifted remainder
  logic            neg_q;
  logic            neg_r;
  logic            by_zero;
  logic            ovf;
  logic            is_rem;
  logic [XLEN-1:0] quo_fix;
  logic [XLEN-1:0] rem_fix;

  assign op_signed = (op == muldiv_pkg::DIV) || (op == muldiv_pkg::REM);
  assign op_rem    = (op == muldiv_pkg::REM) || (op == muldiv_pkg::REMU);
  assign a_neg     = op_signed && a[XLEN-1];
  assign b_neg     = op_signed && b[XLEN-1];
  assign mag_a     = a_neg ? -a : a;
  assign mag_b     = b_neg ? -b : b;

  assign rem_sh  = {rem, quo[XLEN-1]};
  assign fits    = (rem_sh >= {1'b0, dvs});
  assign rem_sub = rem_sh - {1'b0, dvs};

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      quo <= mag_a;
      rem <= '0;
      dvs <= mag_b;
    end
    else if (step)  // One restoring shift-subtract
    begin
      quo <= {quo[XLEN-2:0], fits};
      rem <= fits ? rem_sub[XLEN-1:0] : rem_sh[XLEN-1:0];
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      neg_q   <= 1'b0;
      neg_r   <= 1'b0;
      by_zero <= 1'b0;
      ovf     <= 1'b0;
      is_rem  <= 1'b0;
    end
    else if (start)
    begin
      neg_q   <= a_neg ^ b_neg;
      neg_r   <= a_neg;  // Remainder takes the dividend sign
      by_zero <= (b == '0);
      ovf     <= op_signed && (a == MOST_NEG) && (b == '1);
      is_rem  <= op_rem;
    end
  end

  assign quo_fix = neg_q ? -quo : quo;
  assign rem_fix = neg_r ? -rem : rem;

  // A zero divisor leaves the full dividend in rem, so REM needs no bypass there
  always_comb
  begin
    if (is_rem)
    begin
      res = ovf ? '0 : rem_fix;
    end
    else if (by_zero)
    begin
      res = '1;
    end
    else if (ovf)
    begin
      res = MOST_NEG;
    end
    else
    begin
      res = quo_fix;
    end
  end

  a_no_step_on_start: assert property (@(posedge clk) disable iff (rst) !(start && step))
    else $error("divider stepped in its load cycle");

endmodule

// ==== mul_unit.sv ====
`timescale 1ns/1ps

module mul_unit #(
  parameter int XLEN = 32
) (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   start,
  input  muldiv_pkg::muldiv_op_e op,
  input  logic [XLEN-1:0]        a,
  input  logic [XLEN-1:0]        b,
  output logic                   done,
  output logic [XLEN-1:0]        res
);

  logic        [XLEN:0]     op_a;      // Operands widened by one sign bit
  logic        [XLEN:0]     op_b;
  logic        [XLEN:0]     factor_a;
  logic        [XLEN:0]     factor_b;
  logic                     high_word; // Upper half selected
  logic                     busy;
  logic signed [2*XLEN+1:0] full_prod;
  logic        [2*XLEN-1:0] prod;

  always_comb
  begin
    case (op)
      muldiv_pkg::MULH:
      begin
        op_a = {a[XLEN-1], a};
        op_b = {b[XLEN-1], b};
      end
      muldiv_pkg::MULHSU:
      begin
        op_a = {a[XLEN-1], a};
        op_b = {1'b0, b};
      end
      default:  // MULHU, and MUL whose low word ignores signs
      begin
        op_a = {1'b0, a};
        op_b = {1'b0, b};
      end
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (start)
    begin
      factor_a <= op_a;
      factor_b <= op_b;
    end
  end

  assign full_prod = $signed(factor_a) * $signed(factor_b);

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      busy      <= 1'b0;
      done      <= 1'b0;
      high_word <= 1'b0;
      prod      <= '0;
    end
    else
    begin
      done <= 1'b0;
      if (start)  // Stage one
      begin
        busy      <= 1'b1;
        high_word <= (op != muldiv_pkg::MUL);
      end
      else if (busy)  // Stage two
      begin
        busy <= 1'b0;
        done <= 1'b1;
        prod <= full_prod[2*XLEN-1:0];
      end
    end
  end

  assign res = high_word ? prod[2*XLEN-1:XLEN] : prod[XLEN-1:0];

  a_mul_op: assert property (@(posedge clk) disable iff (rst)
      start |-> (op inside {muldiv_pkg::MUL, muldiv_pkg::MULH,
                            muldiv_pkg::MULHSU, muldiv_pkg::MULHU}))
    else $error("multiplier started with a divide operation");

endmodule

// ==== muldiv_counter.sv ====
`timescale 1ns/1ps

module muldiv_counter #(
  parameter int COUNT = 32
) (
  input  logic clk,
  input  logic rst,
  input  logic load,
  input  logic en,
  output logic last
);

  localparam int CW = $clog2(COUNT + 1);

  logic [CW-1:0] count;  // Iterations still to go

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      count <= '0;
    end
    else if (load)
    begin
      count <= CW'(COUNT);
    end
    else if (en)
    begin
      count <= count - 1'b1;
    end
  end

  assign last = en && (count == CW'(1));  // Final step in progress

  a_no_underflow: assert property (@(posedge clk) disable iff (rst) en |-> (count != '0))
    else $error("divider stepped past its iteration count");

endmodule

// ==== muldiv_ctrl.sv ====
`timescale 1ns/1ps

module muldiv_ctrl (
  input  logic                    clk,
  input  logic                    rst,
  input  muldiv_pkg::muldiv_req_t req,
  input  logic                    last,
  input  logic                    mul_done,
  output logic                    mul_start,
  output logic                    div_start,
  output logic                    step,
  output logic                    is_div,
  output logic                    ready
);

  muldiv_pkg::ctrl_state_e state;
  muldiv_pkg::ctrl_state_e state_next;

  logic req_div;  // Request belongs to the divide group
  logic capture;  // IDLE samples a new request
  logic step_q;
  logic fin;      // Final iteration has been taken

  assign req_div = req.op inside {muldiv_pkg::DIV, muldiv_pkg::DIVU,
                                  muldiv_pkg::REM, muldiv_pkg::REMU};
  assign capture = (state == muldiv_pkg::IDLE) && req.valid;

  // Starts go out in the capture cycle so the datapaths load on the capture edge
  assign mul_start = capture && !req_div;
  assign div_start = capture && req_div;

  always_comb
  begin
    state_next = state;
    case (state)
      muldiv_pkg::IDLE:
      begin
        if (req.valid)
        begin
          state_next = req_div ? muldiv_pkg::DIV_RUN : muldiv_pkg::MUL_LOAD;
        end
      end
      muldiv_pkg::MUL_LOAD: state_next = muldiv_pkg::MUL_CALC;
      muldiv_pkg::MUL_CALC:
      begin
        if (mul_done)
        begin
          state_next = muldiv_pkg::DONE;
        end
      end
      muldiv_pkg::DIV_RUN:
      begin
        if (fin)
        begin
          state_next = muldiv_pkg::DONE;
        end
      end
      default: state_next = muldiv_pkg::IDLE;  // DONE lasts one cycle
    endcase
    if (!req.valid)
    begin
      state_next = muldiv_pkg::IDLE;  // Caller abandoned the operation
    end
  end

  always_ff @(posedge clk or posedge rst)
  begin
    if (rst)
    begin
      state  <= muldiv_pkg::IDLE;
      is_div <= 1'b0;
      step_q <= 1'b0;
      fin    <= 1'b0;
    end
    else
    begin
      state <= state_next;
      if (capture)
      begin
        is_div <= req_div;  // Result select held until the next request
      end
      // Iterations start one cycle after the operands are loaded
      step_q <= (state == muldiv_pkg::DIV_RUN) && (state_next == muldiv_pkg::DIV_RUN) &&
                !last && !fin;
      fin    <= last && (state_next == muldiv_pkg::DIV_RUN);
    end
  end

  assign step  = step_q;
  assign ready = (state == muldiv_pkg::DONE);

  a_last_in_run: assert property (@(posedge clk) disable iff (rst)
      last |-> (state == muldiv_pkg::DIV_RUN))
    else $error("iteration count ended outside a divide");

  a_done_after_load: assert property (@(posedge clk) disable iff (rst)
      mul_done |-> ($past(state) == muldiv_pkg::MUL_LOAD))
    else $error("multiplier finished out of step with its load");

endmodule

// ==== muldiv_pkg.sv ====
package muldiv_pkg;

  // Operation select, encoded as the RISC-V M-extension funct3
  typedef enum logic [2:0] {
    MUL    = 3'b000,
    MULH   = 3'b001,
    MULHSU = 3'b010,
    MULHU  = 3'b011,
    DIV    = 3'b100,
    DIVU   = 3'b101,
    REM    = 3'b110,
    REMU   = 3'b111
  } muldiv_op_e;

  // Request from the caller, held steady until ready
  typedef struct packed {
    logic              valid;
    muldiv_op_e        op;
    logic       [31:0] a;  // rs1 operand
    logic       [31:0] b;  // rs2 operand
  } muldiv_req_t;

  // Response back to the caller
  typedef struct packed {
    logic        ready;  // One-cycle completion pulse
    logic [31:0] res;
  } muldiv_resp_t;

  // Controller states
  typedef enum logic [2:0] {
    IDLE     = 3'd0,
    MUL_LOAD = 3'd1,  // Operands registered in mul_unit
    MUL_CALC = 3'd2,  // Product being registered
    DIV_RUN  = 3'd3,  // Divider iterating
    DONE     = 3'd4   // Result presented with ready
  } ctrl_state_e;

endpackage
